/* src/opq_pkg.sv */
package opq_pkg;

    // queue geometry. One slot always stays free so capacity is Q_LENGTH-1.
    localparam int Q_LENGTH = 16;
    localparam int TAG_W = 7;
    localparam int M_W = 8;              // modifiable word, wait bit plus tag or value.
    localparam int N_W = 8;              // payload, written once at push.
    localparam int ENTRY_W = M_W + N_W;

    // apb word addresses.
    localparam logic [7:0] ADDR_PUSH = 8'h00;
    localparam logic [7:0] ADDR_HEAD = 8'h04;
    localparam logic [7:0] ADDR_POP = 8'h08;
    localparam logic [7:0] ADDR_STATUS = 8'h0C;
    localparam logic [7:0] ADDR_CTRL = 8'h10;

    // bit positions inside the STATUS and CTRL words.
    localparam int STAT_EMPTY = 0;
    localparam int STAT_FULL = 1;
    localparam int STAT_HEAD_READY = 2;
    localparam int CTRL_FLUSH = 0;

    // the modifiable word seen two ways.
    // a set wait bit means the slot still waits for its producer tag.
    // a clear wait bit means the operand value has been captured.
    typedef union packed {
        struct packed {
            logic             wait_bit;
            logic [TAG_W-1:0] tag;
        } pending;
        struct packed {
            logic             wait_bit;
            logic [TAG_W-1:0] value;
        } ready;
    } m_word_u;

endpackage

/* src/op_queue.sv */
module op_queue (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [opq_pkg::M_W-1:0]                   m_din,
    input  logic [opq_pkg::N_W-1:0]                   n_din,
    input  logic                                      wr,
    input  logic                                      rd,
    input  logic                                      flush,
    input  logic [opq_pkg::Q_LENGTH-1:0]              modify_vector,
    input  logic [opq_pkg::Q_LENGTH*opq_pkg::M_W-1:0] new_m_vector,
    output logic                                      full,
    output logic                                      empty,
    output logic [opq_pkg::Q_LENGTH*opq_pkg::M_W-1:0] old_m_vector,
    output logic [opq_pkg::ENTRY_W-1:0]               dout
);
    import opq_pkg::*;

    logic [Q_LENGTH-1:0] ptr_wr;
    logic [Q_LENGTH-1:0] ptr_rd;
    logic [Q_LENGTH-1:0] rot_ptr_wr;
    logic [Q_LENGTH-1:0] rot_ptr_rd;
    logic                ld_wr;
    logic                ld_rd;

    logic [M_W-1:0] m_q [Q_LENGTH];
    logic [N_W-1:0] n_q [Q_LENGTH];

    // each pointer advances by one slot per accepted access.
    assign rot_ptr_wr = {ptr_wr[Q_LENGTH-2:0], ptr_wr[Q_LENGTH-1]};
    assign rot_ptr_rd = {ptr_rd[Q_LENGTH-2:0], ptr_rd[Q_LENGTH-1]};

    assign empty = (ptr_rd == ptr_wr);
    assign full = (ptr_rd == rot_ptr_wr); // the write pointer is one step behind the read pointer.

    assign ld_wr = wr && !full;
    assign ld_rd = rd && !empty;

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            ptr_wr <= Q_LENGTH'(1);
            ptr_rd <= Q_LENGTH'(1);
        end else begin
            if (ld_wr) begin
                ptr_wr <= rot_ptr_wr;
            end
            if (ld_rd) begin
                ptr_rd <= rot_ptr_rd;
            end
        end
    end

    // slot storage.
    // A push owns the whole slot in its cycle, so a broadcast hitting the
    // same slot then is dropped and the pushed word is kept as written.
    for (genvar i = 0; i < Q_LENGTH; i++) begin : g_slot
        logic ld;

        assign ld = ld_wr && ptr_wr[i];

        always_ff @(posedge clk) begin
            if (rst || flush) begin
                m_q[i] <= '0;
                n_q[i] <= '0;
            end else if (ld) begin
                m_q[i] <= m_din;
                n_q[i] <= n_din;
            end else if (modify_vector[i]) begin
                m_q[i] <= new_m_vector[i*M_W +: M_W]; // the payload is never touched here.
            end
        end

        assign old_m_vector[i*M_W +: M_W] = m_q[i];
    end

    // and-or select of the head slot, the read pointer is one-hot.
    always_comb begin
        dout = '0;
        for (int i = 0; i < Q_LENGTH; i++) begin
            dout = dout | ({m_q[i], n_q[i]} & {ENTRY_W{ptr_rd[i]}});
        end
    end

    a_ptr_onehot : assert property (
        @(posedge clk) disable iff (rst)
        $onehot(ptr_wr) && $onehot(ptr_rd)
    ) else $error("queue pointer lost its one-hot form");

    a_full_empty : assert property (
        @(posedge clk) disable iff (rst)
        !(full && empty)
    ) else $error("queue reports full and empty together");

endmodule

/* src/wakeup_match.sv */
module wakeup_match (
    input  logic [opq_pkg::Q_LENGTH*opq_pkg::M_W-1:0] old_m_vector,
    input  logic                                      wb_valid,
    input  logic [opq_pkg::TAG_W-1:0]                 wb_tag,
    input  logic [opq_pkg::TAG_W-1:0]                 wb_value,
    output logic [opq_pkg::Q_LENGTH-1:0]              modify_vector,
    output logic [opq_pkg::Q_LENGTH*opq_pkg::M_W-1:0] new_m_vector
);
    import opq_pkg::*;

    m_word_u old_w [Q_LENGTH];
    m_word_u ready_w;

    // every slot that matches gets the same captured value.
    always_comb begin
        ready_w.ready.wait_bit = 1'b0;
        ready_w.ready.value = wb_value;
    end

    for (genvar i = 0; i < Q_LENGTH; i++) begin : g_match
        assign old_w[i] = old_m_vector[i*M_W +: M_W];

        // only slots still waiting can match, so captured values never alias a tag.
        assign modify_vector[i] = wb_valid
                                  && old_w[i].pending.wait_bit
                                  && (old_w[i].pending.tag == wb_tag);

        assign new_m_vector[i*M_W +: M_W] = ready_w;
    end

    always_comb begin
        a_no_modify_idle : assert final (wb_valid || (modify_vector == '0))
            else $error("modify raised without a valid broadcast");
    end

endmodule

/* src/opq_apb_regs.sv */
module opq_apb_regs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [7:0]                  paddr,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [31:0]                 pwdata,
    input  logic                        full,
    input  logic                        empty,
    input  logic [opq_pkg::ENTRY_W-1:0] head,
    output logic [31:0]                 prdata,
    output logic                        pready,
    output logic                        pslverr,
    output logic [opq_pkg::M_W-1:0]     m_din,
    output logic [opq_pkg::N_W-1:0]     n_din,
    output logic                        wr,
    output logic                        rd,
    output logic                        flush
);
    import opq_pkg::*;

    logic               access;
    logic               head_first;
    logic               head_wait;
    logic [ENTRY_W-1:0] head_q;
    m_word_u            head_m;
    logic               head_ready;
    logic               err;
    logic               ok_wr;

    assign access = psel && penable;
    assign head_m = head[ENTRY_W-1 -: M_W];
    assign head_ready = !empty && !head_m.pending.wait_bit;

    // first cycle of a HEAD read access, where the head gets sampled.
    assign head_first = access && !pwrite && (paddr == ADDR_HEAD) && !head_wait;

    // legality of the access against the register map.
    always_comb begin
        case (paddr)
            ADDR_PUSH: err = !pwrite || full;
            ADDR_POP: err = !pwrite || !head_ready;  // a pending head may not leave.
            ADDR_CTRL: err = !pwrite;
            ADDR_HEAD: err = pwrite || empty;
            ADDR_STATUS: err = pwrite;
            default: err = 1'b1;
        endcase
    end

    assign pready = access && !head_first;
    assign pslverr = pready && err;

    // queue strobes. Writes complete in one cycle so these are single pulses.
    assign ok_wr = pready && !err && pwrite;
    assign wr = ok_wr && (paddr == ADDR_PUSH);
    assign rd = ok_wr && (paddr == ADDR_POP);
    assign flush = ok_wr && (paddr == ADDR_CTRL) && pwdata[CTRL_FLUSH];

    assign m_din = pwdata[N_W +: M_W];
    assign n_din = pwdata[0 +: N_W];

    always_ff @(posedge clk) begin
        if (rst) begin
            head_wait <= 1'b0;
        end else begin
            head_wait <= head_first; // high only for the completing cycle.
        end
    end

    always_ff @(posedge clk) begin
        if (head_first) begin
            head_q <= head;
        end
    end

    always_comb begin
        prdata = '0;
        if (pready && !pwrite && !err) begin
            case (paddr)
                ADDR_HEAD: begin
                    prdata[ENTRY_W-1:0] = head_q;
                end
                ADDR_STATUS: begin
                    prdata[STAT_EMPTY] = empty;
                    prdata[STAT_FULL] = full;
                    prdata[STAT_HEAD_READY] = head_ready;
                end
                default: begin
                    prdata = '0;
                end
            endcase
        end
    end

    a_rd_ready_head : assert property (
        @(posedge clk) disable iff (rst)
        rd |-> !head_m.pending.wait_bit
    ) else $error("pop issued while the head still waits");

    // an accepted push must leave at least one entry in the queue.
    a_push_fills : assert property (
        @(posedge clk) disable iff (rst)
        wr |=> !empty
    ) else $error("queue empty right after an accepted push");

endmodule

/* src/opq_top.sv */
module opq_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic [7:0]                paddr,
    input  logic                      psel,
    input  logic                      penable,
    input  logic                      pwrite,
    input  logic [31:0]               pwdata,
    output logic [31:0]               prdata,
    output logic                      pready,
    output logic                      pslverr,
    input  logic                      wb_valid,
    input  logic [opq_pkg::TAG_W-1:0] wb_tag,
    input  logic [opq_pkg::TAG_W-1:0] wb_value
);
    import opq_pkg::*;

    logic [M_W-1:0]          m_din;
    logic [N_W-1:0]          n_din;
    logic                    wr;
    logic                    rd;
    logic                    flush;
    logic                    full;
    logic                    empty;
    logic [ENTRY_W-1:0]      dout;
    logic [Q_LENGTH-1:0]     modify_vector;
    logic [Q_LENGTH*M_W-1:0] old_m_vector;
    logic [Q_LENGTH*M_W-1:0] new_m_vector;

    opq_apb_regs i_opq_apb_regs (
        .clk     (clk),
        .rst     (rst),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .full    (full),
        .empty   (empty),
        .head    (dout),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .m_din   (m_din),
        .n_din   (n_din),
        .wr      (wr),
        .rd      (rd),
        .flush   (flush)
    );

    op_queue i_op_queue (
        .clk           (clk),
        .rst           (rst),
        .m_din         (m_din),
        .n_din         (n_din),
        .wr            (wr),
        .rd            (rd),
        .flush         (flush),
        .modify_vector (modify_vector),
        .new_m_vector  (new_m_vector),
        .full          (full),
        .empty         (empty),
        .old_m_vector  (old_m_vector),
        .dout          (dout)
    );

    wakeup_match i_wakeup_match (
        .old_m_vector  (old_m_vector),
        .wb_valid      (wb_valid),
        .wb_tag        (wb_tag),
        .wb_value      (wb_value),
        .modify_vector (modify_vector),
        .new_m_vector  (new_m_vector)
    );

endmodule

/* sim/tb_opq.sv */
module tb_opq;
    timeunit 1ns;
    timeprecision 1ps;

    import opq_pkg::*;

    localparam int CAPACITY = Q_LENGTH - 1;
    localparam int RANDOM_OPS = 400;
    localparam int PLANNED_ACCESSES = 1100;  // directed part plus two accesses per random op.
    localparam int CYCLE_LIMIT = 40 * PLANNED_ACCESSES + 200;

    logic             clk;
    logic             rst;
    logic [7:0]       paddr;
    logic             psel;
    logic             penable;
    logic             pwrite;
    logic [31:0]      pwdata;
    logic [31:0]      prdata;
    logic             pready;
    logic             pslverr;
    logic             wb_valid;
    logic [TAG_W-1:0] wb_tag;
    logic [TAG_W-1:0] wb_value;

    // reference queue, entry 0 is the head.
    logic [M_W-1:0] model_m [Q_LENGTH];
    logic [N_W-1:0] model_n [Q_LENGTH];
    int             model_count;
    logic [31:0]    lfsr_state;
    int             cycle_count = 0;

    opq_top i_opq_top (
        .clk      (clk),
        .rst      (rst),
        .paddr    (paddr),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr),
        .wb_valid (wb_valid),
        .wb_tag   (wb_tag),
        .wb_value (wb_value)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("sim failed");
            $fatal(1, "timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_state[0]};
            lfsr_state = lfsr_step(lfsr_state);
        end
        return r;
    endfunction

    function automatic logic [TAG_W-1:0] small_tag();
        return 7'h40 | 7'(rand_bits(2));  // four tags keep matches frequent.
    endfunction

    function automatic void model_wakeup(input logic [TAG_W-1:0] tag,
                                         input logic [TAG_W-1:0] value);
        for (int i = 0; i < model_count; i++) begin
            if (model_m[i][M_W-1] && (model_m[i][TAG_W-1:0] == tag)) begin
                model_m[i] = {1'b0, value};
            end
        end
    endfunction

    function automatic void model_pop();
        for (int i = 1; i < model_count; i++) begin
            model_m[i-1] = model_m[i];
            model_n[i-1] = model_n[i];
        end
        model_count = model_count - 1;
    endfunction

    // returns {head_ready, full, empty, head entry}.
    function automatic logic [18:0] expected_head();
        logic [15:0] head;
        logic        e;
        logic        f;
        logic        hr;
        e = (model_count == 0);
        f = (model_count == CAPACITY);
        head = e ? 16'h0 : {model_m[0], model_n[0]};
        hr = !e && !model_m[0][M_W-1];
        return {hr, f, e, head};
    endfunction

    task automatic check_eq(input string name, input logic [31:0] actual,
                            input logic [31:0] expected);
        if (actual !== expected) begin
            $display("error at %0t ns: %s is 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("sim failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // one APB transfer, optionally with a broadcast in its first access cycle.
    task automatic apb_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata, input logic bc_en,
                              input logic [TAG_W-1:0] bc_tag, input logic [TAG_W-1:0] bc_value,
                              output logic [31:0] rdata, output logic err);
        int waits;
        waits = 0;
        @(posedge clk);
        #0.5;
        paddr = addr;
        pwrite = write;
        pwdata = wdata;
        psel = 1'b1;
        penable = 1'b0;
        @(posedge clk);
        #0.5;
        penable = 1'b1;
        wb_valid = bc_en;
        wb_tag = bc_tag;
        wb_value = bc_value;
        @(negedge clk);
        while (!pready) begin
            waits = waits + 1;
            @(posedge clk);
            #0.5;
            wb_valid = 1'b0;
            @(negedge clk);
        end
        // only a HEAD read has a wait state, every other access completes at once.
        check_eq("pready wait states", 32'(waits),
                 (!write && (addr == ADDR_HEAD)) ? 32'd1 : 32'd0);
        rdata = prdata;
        err = pslverr;
        @(posedge clk);
        #0.5;
        psel = 1'b0;
        penable = 1'b0;
        wb_valid = 1'b0;
    endtask

    task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata,
                             output logic err);
        logic [31:0] unused;
        apb_access(1'b1, addr, wdata, 1'b0, '0, '0, unused, err);
    endtask

    task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata,
                            output logic err);
        apb_access(1'b0, addr, 32'd0, 1'b0, '0, '0, rdata, err);
    endtask

    task automatic broadcast(input logic [TAG_W-1:0] tag, input logic [TAG_W-1:0] value);
        @(posedge clk);
        #0.5;
        wb_valid = 1'b1;
        wb_tag = tag;
        wb_value = value;
        @(posedge clk);
        #0.5;
        wb_valid = 1'b0;
        model_wakeup(tag, value);
    endtask

    task automatic check_status();
        logic [31:0] data;
        logic        err;
        logic [18:0] exp;
        exp = expected_head();
        apb_read(ADDR_STATUS, data, err);
        check_eq("status pslverr", 32'(err), 32'd0);
        check_eq("status prdata", data, {29'd0, exp[18:16]});
    endtask

    task automatic check_head();
        logic [31:0] data;
        logic        err;
        logic [18:0] exp;
        exp = expected_head();
        apb_read(ADDR_HEAD, data, err);
        check_eq("head pslverr", 32'(err), 32'(model_count == 0));
        if (model_count != 0) begin
            check_eq("head prdata", data, {16'd0, exp[15:0]});
        end
    endtask

    task automatic push_entry(input logic [M_W-1:0] m, input logic [N_W-1:0] n,
                              input logic bc_en, input logic [TAG_W-1:0] bc_tag,
                              input logic [TAG_W-1:0] bc_value);
        logic [31:0] data;
        logic        err;
        logic        exp_err;
        exp_err = (model_count == CAPACITY);
        apb_access(1'b1, ADDR_PUSH, {16'd0, m, n}, bc_en, bc_tag, bc_value, data, err);
        check_eq("push pslverr", 32'(err), 32'(exp_err));
        if (bc_en) begin
            model_wakeup(bc_tag, bc_value);  // the pushed word itself is not woken.
        end
        if (!exp_err) begin
            model_m[model_count] = m;
            model_n[model_count] = n;
            model_count = model_count + 1;
        end
    endtask

    task automatic push_word(input logic [M_W-1:0] m, input logic [N_W-1:0] n);
        push_entry(m, n, 1'b0, '0, '0);
    endtask

    task automatic pop_entry();
        logic err;
        logic exp_err;
        exp_err = (model_count == 0) || model_m[0][M_W-1];
        apb_write(ADDR_POP, 32'd0, err);
        check_eq("pop pslverr", 32'(err), 32'(exp_err));
        if (!exp_err) begin
            model_pop();
        end
    endtask

    task automatic expect_error(input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata);
        logic [31:0] data;
        logic        err;
        apb_access(write, addr, wdata, 1'b0, '0, '0, data, err);
        check_eq("pslverr on bad access", 32'(err), 32'd1);
    endtask

    // a pending head is first shown blocking, then woken with its own tag.
    task automatic drain_queue();
        while (model_count > 0) begin
            check_head();
            if (model_m[0][M_W-1]) begin
                pop_entry();
                broadcast(model_m[0][TAG_W-1:0], model_m[0][TAG_W-1:0] ^ 7'h2a);
                check_head();
            end
            pop_entry();
            check_status();
        end
    endtask

    task automatic random_test();
        logic [2:0]       op;
        logic [M_W-1:0]   m;
        logic [N_W-1:0]   n;
        logic             bc;
        logic [TAG_W-1:0] tag;
        logic [TAG_W-1:0] value;
        for (int i = 0; i < RANDOM_OPS; i++) begin
            op = 3'(rand_bits(3));
            case (op)
                3'd0, 3'd1, 3'd2: begin
                    if (rand_bits(1) == 32'd1) begin
                        m = {1'b1, small_tag()};
                    end else begin
                        m = {1'b0, 7'(rand_bits(TAG_W))};
                    end
                    n = 8'(rand_bits(N_W));
                    bc = (rand_bits(2) == 32'd0);
                    tag = small_tag();
                    value = 7'(rand_bits(TAG_W));
                    push_entry(m, n, bc, tag, value);
                end
                3'd3, 3'd4: pop_entry();
                3'd5: begin
                    tag = small_tag();
                    value = 7'(rand_bits(TAG_W));
                    broadcast(tag, value);
                end
                default: check_head();
            endcase
            check_status();
        end
        drain_queue();
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        paddr = '0;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        pwdata = '0;
        wb_valid = 1'b0;
        wb_tag = '0;
        wb_value = '0;
        lfsr_state = 32'hd5da_ac2c;
        model_count = 0;
        repeat (8) @(posedge clk);
        #0.5;
        rst = 1'b0;
        @(negedge clk);
        check_eq("pready", 32'(pready), 32'd0);
        check_eq("pslverr", 32'(pslverr), 32'd0);
        check_status();

        // ready entries leave in push order.
        for (int i = 0; i < 5; i++) begin
            push_word(8'(8'h31 + i), 8'(8'hc0 + i));
        end
        check_status();
        drain_queue();
        check_status();

        // fill to capacity, overflow, then underflow.
        for (int i = 0; i < CAPACITY; i++) begin
            push_word(8'(i), 8'(8'h80 + i));
        end
        check_status();
        push_word(8'h7e, 8'hee);
        check_status();
        check_head();
        drain_queue();
        pop_entry();
        check_head();
        check_status();

        // pending head blocks its pop until the tag is broadcast.
        push_word({1'b1, 7'h21}, 8'ha5);
        push_word({1'b0, 7'h21}, 8'h5a);  // ready value equal to the tag.
        check_status();
        pop_entry();
        check_head();
        broadcast(7'h21, 7'h5c);
        check_head();
        check_status();
        drain_queue();

        // one broadcast wakes several slots but not the one pushed with it.
        push_word({1'b1, 7'h11}, 8'h01);
        push_word({1'b0, 7'h11}, 8'h02);
        push_word({1'b1, 7'h22}, 8'h03);
        push_word({1'b1, 7'h11}, 8'h04);
        push_entry({1'b1, 7'h11}, 8'h05, 1'b1, 7'h11, 7'h6b);
        check_status();
        drain_queue();

        // flush, restart, and illegal accesses.
        push_word({1'b1, 7'h33}, 8'h10);
        push_word({1'b0, 7'h44}, 8'h11);
        expect_error(1'b1, ADDR_HEAD, 32'h0000_0102);
        expect_error(1'b1, ADDR_STATUS, 32'h0000_0007);
        expect_error(1'b0, ADDR_PUSH, 32'd0);
        expect_error(1'b0, ADDR_POP, 32'd0);
        expect_error(1'b0, ADDR_CTRL, 32'd0);
        expect_error(1'b0, 8'h14, 32'd0);
        expect_error(1'b1, 8'h14, 32'h0000_0001);
        expect_error(1'b1, 8'h02, 32'h0000_0203);
        check_status();
        check_head();
        flush_checked(1'b0);
        check_status();
        flush_checked(1'b1);
        check_status();
        check_head();
        push_word({1'b0, 7'h01}, 8'h20);
        push_word({1'b1, 7'h02}, 8'h21);
        check_head();
        check_status();
        drain_queue();

        random_test();
        check_status();

        $display("sim passed");
        $finish;
    end

    // CTRL write, only bit 0 set empties the queue.
    task automatic flush_checked(input logic do_flush);
        logic err;
        apb_write(ADDR_CTRL, {31'd0, do_flush}, err);
        check_eq("ctrl pslverr", 32'(err), 32'd0);
        if (do_flush) begin
            model_count = 0;
        end
    endtask

endmodule

/* flist.f */
src/opq_pkg.sv
src/op_queue.sv
src/wakeup_match.sv
src/opq_apb_regs.sv
src/opq_top.sv
sim/tb_opq.sv

/* Makefile */
VERILATOR  ?= verilator
TOP        := tb_opq
FLIST      := flist.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -j 0 --timescale 1ns/1ps
LINT_FLAGS := --lint-only --timing --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR)
